//--- src/timer_cfg.svh
/*
 * Machine timer configuration
 * Bus widths, register map offsets and the default response latency
 */

`ifndef TIMER_CFG_SVH
`define TIMER_CFG_SVH

// Bus widths, only 32-bit data is supported
`define TIMER_DATA_WIDTH 32
`define TIMER_ADDR_WIDTH 32

// Decoded low address bits, a 64 KiB window
`define TIMER_OFFSET_WIDTH 16

// Register map offsets within the window
`define TIMER_MTIMECMP_LOW  16'h4000
`define TIMER_MTIMECMP_HIGH 16'h4004
`define TIMER_MTIME_LOW     16'hBFF8
`define TIMER_MTIME_HIGH    16'hBFFC

// Cycles between request and response, 0 or 1
`define TIMER_ACCESS_LATENCY 1

`endif

//--- src/timer_pkg.sv
/*
 * Machine timer types
 * Vector types shared by the timer RTL and its testbench
 */

`include "timer_cfg.svh"

package timer_pkg;

  // One bus word
  typedef logic [`TIMER_DATA_WIDTH-1:0] bus_data_t;

  // Full bus address, only the low offset bits are decoded
  typedef logic [`TIMER_ADDR_WIDTH-1:0] bus_addr_t;

  // One enable per byte of the bus word
  typedef logic [`TIMER_DATA_WIDTH/8-1:0] bus_be_t;

  // Decoded register offset
  typedef logic [`TIMER_OFFSET_WIDTH-1:0] reg_offset_t;

  // mtime and mtimecmp are both two bus words wide
  typedef logic [2*`TIMER_DATA_WIDTH-1:0] timer_val_t;

  // Register index
  //   0 mtime low, 1 mtime high, 2 mtimecmp low, 3 mtimecmp high
  // Bit 1 picks mtimecmp over mtime, bit 0 picks the high half
  typedef logic [1:0] reg_idx_t;

endpackage

//--- src/timer_decode.sv
/*
 * Machine timer address decode
 * Maps the low address bits to a register index and forms the write strobe
 */

`timescale 1ns/1ps

`include "timer_cfg.svh"

module timer_decode (
  input  logic                 timer_req_i,
  input  timer_pkg::bus_addr_t timer_addr_i,
  input  logic                 timer_we_i,
  input  timer_pkg::bus_be_t   timer_be_i,
  output timer_pkg::reg_idx_t  reg_idx_o,
  output logic                 addr_hit_o,
  output logic                 wr_en_o
);

  import timer_pkg::*;

  reg_offset_t offset;
  logic        full_be;

  // Upper address bits are decoded outside the timer
  assign offset = timer_addr_i[`TIMER_OFFSET_WIDTH-1:0];

  // Register index and hit flag
  always_comb begin
    reg_idx_o  = 2'd0;
    addr_hit_o = 1'b1;
    case (offset)
      `TIMER_MTIME_LOW: begin
        reg_idx_o = 2'd0;
      end
      `TIMER_MTIME_HIGH: begin
        reg_idx_o = 2'd1;
      end
      `TIMER_MTIMECMP_LOW: begin
        reg_idx_o = 2'd2;
      end
      `TIMER_MTIMECMP_HIGH: begin
        reg_idx_o = 2'd3;
      end
      default: begin
        // No register at this offset
        addr_hit_o = 1'b0;
      end
    endcase
  end

  // Partial writes are dropped here and never reach the registers
  assign full_be = &timer_be_i;

  // Single write strobe for the register block
  assign wr_en_o = timer_req_i & timer_we_i & addr_hit_o & full_be;

endmodule

//--- src/timer_counter.sv
/*
 * Machine timer registers
 * Free-running 64-bit mtime, the mtimecmp compare value and the sticky interrupt
 */

`timescale 1ns/1ps

`include "timer_cfg.svh"

module timer_counter (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  wr_en_i,
  input  timer_pkg::reg_idx_t   reg_idx_i,
  input  timer_pkg::bus_data_t  wdata_i,
  output timer_pkg::timer_val_t mtime_o,
  output timer_pkg::timer_val_t mtimecmp_o,
  output logic                  intr_o
);

  import timer_pkg::*;

  localparam int unsigned DW = `TIMER_DATA_WIDTH;

  logic       mtime_lo_we;
  logic       mtime_hi_we;
  logic       cmp_lo_we;
  logic       cmp_hi_we;
  logic       cmp_we;
  timer_val_t mtime_q;
  timer_val_t mtime_d;
  timer_val_t mtime_inc;
  timer_val_t mtimecmp_q;
  timer_val_t mtimecmp_d;
  logic       intr_q;
  logic       intr_d;

  // Per-half write enables from the register index
  assign mtime_lo_we = wr_en_i & ~reg_idx_i[1] & ~reg_idx_i[0];
  assign mtime_hi_we = wr_en_i & ~reg_idx_i[1] &  reg_idx_i[0];
  assign cmp_lo_we   = wr_en_i &  reg_idx_i[1] & ~reg_idx_i[0];
  assign cmp_hi_we   = wr_en_i &  reg_idx_i[1] &  reg_idx_i[0];
  assign cmp_we      = cmp_lo_we | cmp_hi_we;

  // One 64-bit increment, so the low half carries into the high half
  assign mtime_inc = mtime_q + 64'd1;

  // A written half takes the bus word, the other half keeps counting
  assign mtime_d = {(mtime_hi_we ? wdata_i : mtime_inc[2*DW-1:DW]),
                    (mtime_lo_we ? wdata_i : mtime_inc[DW-1:0])};

  assign mtimecmp_d = {(cmp_hi_we ? wdata_i : mtimecmp_q[2*DW-1:DW]),
                       (cmp_lo_we ? wdata_i : mtimecmp_q[DW-1:0])};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtime_q <= '0;
    end else begin
      mtime_q <= mtime_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtimecmp_q <= '0;
    end else if (cmp_we) begin
      mtimecmp_q <= mtimecmp_d;
    end
  end

  // Sticky until software writes mtimecmp, the write wins over a new match
  assign intr_d = ((mtime_q >= mtimecmp_q) | intr_q) & ~cmp_we;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      intr_q <= 1'b0;
    end else begin
      intr_q <= intr_d;
    end
  end

  assign mtime_o    = mtime_q;
  assign mtimecmp_o = mtimecmp_q;
  assign intr_o     = intr_q;

endmodule

//--- src/timer_readback.sv
/*
 * Machine timer read path
 * Selects the addressed register half and returns it after the access latency
 */

`timescale 1ns/1ps

`include "timer_cfg.svh"

module timer_readback #(
  // Response latency of 0 or 1 cycles
  parameter int unsigned AccessLatency = `TIMER_ACCESS_LATENCY
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_i,
  input  timer_pkg::reg_idx_t   reg_idx_i,
  input  logic                  addr_hit_i,
  input  timer_pkg::timer_val_t mtime_i,
  input  timer_pkg::timer_val_t mtimecmp_i,
  output logic                  rvalid_o,
  output timer_pkg::bus_data_t  rdata_o,
  output logic                  err_o
);

  import timer_pkg::*;

  localparam int unsigned DW = `TIMER_DATA_WIDTH;

  bus_data_t rdata_d;
  logic      err_d;

  // Read word from the current register values
  always_comb begin
    rdata_d = '0;
    err_d   = 1'b0;
    if (!addr_hit_i) begin
      err_d = 1'b1;
    end else begin
      case (reg_idx_i)
        2'd0:    rdata_d = mtime_i[DW-1:0];
        2'd1:    rdata_d = mtime_i[2*DW-1:DW];
        2'd2:    rdata_d = mtimecmp_i[DW-1:0];
        default: rdata_d = mtimecmp_i[2*DW-1:DW];
      endcase
    end
  end

  if (AccessLatency == 1) begin : gen_latency1
    bus_data_t rdata_q;
    logic      err_q;
    logic      rvalid_q;

    // Capture the read word and error flag on each request
    always_ff @(posedge clk_i) begin
      if (req_i) begin
        rdata_q <= rdata_d;
        err_q   <= err_d;
      end
    end

    // One response per request in the next cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rvalid_q <= 1'b0;
      end else begin
        rvalid_q <= req_i;
      end
    end

    assign rvalid_o = rvalid_q;
    assign rdata_o  = rdata_q;
    assign err_o    = err_q;
  end else begin : gen_latency0
    // Response in the same cycle as the request
    assign rvalid_o = req_i;
    assign rdata_o  = rdata_d;
    assign err_o    = err_d;
  end

endmodule

//--- src/rv_timer.sv
/*
 * RISC-V machine timer
 * Memory-mapped mtime and mtimecmp with a level interrupt on a plain request bus
 */

`timescale 1ns/1ps

`include "timer_cfg.svh"

module rv_timer #(
  // Response latency in cycles, 0 or 1
  parameter int unsigned AccessLatency = `TIMER_ACCESS_LATENCY
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Bus request
  input  logic                 timer_req_i,
  input  timer_pkg::bus_addr_t timer_addr_i,
  input  logic                 timer_we_i,
  input  timer_pkg::bus_be_t   timer_be_i,
  input  timer_pkg::bus_data_t timer_wdata_i,
  // Bus response
  output logic                 timer_rvalid_o,
  output timer_pkg::bus_data_t timer_rdata_o,
  output logic                 timer_err_o,
  // Level interrupt
  output logic                 timer_intr_o
);

  import timer_pkg::*;

  reg_idx_t   reg_idx;
  logic       addr_hit;
  logic       wr_en;
  timer_val_t mtime;
  timer_val_t mtimecmp;

  // Address match and write strobe
  timer_decode timer_decode_i (
    .timer_req_i  (timer_req_i),
    .timer_addr_i (timer_addr_i),
    .timer_we_i   (timer_we_i),
    .timer_be_i   (timer_be_i),
    .reg_idx_o    (reg_idx),
    .addr_hit_o   (addr_hit),
    .wr_en_o      (wr_en)
  );

  // Counter, compare register and interrupt
  timer_counter timer_counter_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wr_en_i    (wr_en),
    .reg_idx_i  (reg_idx),
    .wdata_i    (timer_wdata_i),
    .mtime_o    (mtime),
    .mtimecmp_o (mtimecmp),
    .intr_o     (timer_intr_o)
  );

  // Read data and response timing
  timer_readback #(
    .AccessLatency (AccessLatency)
  ) timer_readback_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (timer_req_i),
    .reg_idx_i  (reg_idx),
    .addr_hit_i (addr_hit),
    .mtime_i    (mtime),
    .mtimecmp_i (mtimecmp),
    .rvalid_o   (timer_rvalid_o),
    .rdata_o    (timer_rdata_o),
    .err_o      (timer_err_o)
  );

endmodule

//--- test/tb_rv_timer.sv
/*
 * Machine timer testbench
 * Drives the bus, predicts mtime, mtimecmp and the interrupt, and checks each response
 */

`timescale 1ns/1ps

`include "timer_cfg.svh"

module tb_rv_timer;

  import timer_pkg::*;

  localparam int unsigned CLK_PERIOD   = 8;
  localparam int unsigned RESET_CYCLES = 3;
  localparam int unsigned RESP_TIMEOUT = 4;
  localparam int unsigned INTR_LEAD    = 40;

  // Cycle budget of each test, summed for the watchdog
  localparam int unsigned TEST_CYCLES = 20 + 40 + 200 + 100 + 60;
  localparam int unsigned WATCHDOG_CYCLES = RESET_CYCLES + TEST_CYCLES + 200;

  localparam bus_addr_t ADDR_MTIME_LO = bus_addr_t'(`TIMER_MTIME_LOW);
  localparam bus_addr_t ADDR_MTIME_HI = bus_addr_t'(`TIMER_MTIME_HIGH);
  localparam bus_addr_t ADDR_CMP_LO   = bus_addr_t'(`TIMER_MTIMECMP_LOW);
  localparam bus_addr_t ADDR_CMP_HI   = bus_addr_t'(`TIMER_MTIMECMP_HIGH);

  logic      clk;
  logic      rst_n;
  logic      req;
  bus_addr_t addr;
  logic      we;
  bus_be_t   be;
  bus_data_t wdata;
  logic      rvalid;
  bus_data_t rdata;
  logic      err;
  logic      intr;

  // Reference model, mtime equals mtime_ref in cycle ref_cyc and counts from there
  longint unsigned cyc;
  longint unsigned ref_cyc;
  longint unsigned req_cycle;
  timer_val_t      mtime_ref;
  timer_val_t      cmp_ref;

  logic [31:0] lfsr_state;
  int unsigned n_pass;
  int unsigned n_fail;
  int unsigned test_fail_start;

  rv_timer rv_timer_i (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .timer_req_i    (req),
    .timer_addr_i   (addr),
    .timer_we_i     (we),
    .timer_be_i     (be),
    .timer_wdata_i  (wdata),
    .timer_rvalid_o (rvalid),
    .timer_rdata_o  (rdata),
    .timer_err_o    (err),
    .timer_intr_o   (intr)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  // Clock edges since reset was released
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  // One response exactly one cycle after every sampled request, none otherwise
  assert property (@(posedge clk) disable iff (!rst_n) rvalid == $past(req))
  else begin
    $display("CHECK FAILED timer_rvalid_o expected 0x%h actual 0x%h",
             $past(req), $sampled(rvalid));
    n_fail++;
  end

  always @(negedge clk) begin
    if (!rst_n) begin
      assert (rvalid == 1'b0)
      else begin
        $display("CHECK FAILED timer_rvalid_o expected 0x0 actual 0x%h", rvalid);
        n_fail++;
      end
    end
  end

  // Galois LFSR, stepped once for every bit taken
  function automatic logic [31:0] rand_bits(input int unsigned nbits);
    logic [31:0] val;
    logic        lsb;
    val = '0;
    for (int unsigned i = 0; i < nbits; i++) begin
      lsb = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (lsb) begin
        lfsr_state = lfsr_state ^ 32'h8020_0003;
      end
      val = {val[30:0], lsb};
    end
    return val;
  endfunction

  task automatic compare_word(input string name, input bus_data_t exp, input bus_data_t act);
    assert (act === exp) begin
      n_pass++;
    end else begin
      $display("CHECK FAILED %s expected 0x%h actual 0x%h", name, exp, act);
      n_fail++;
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    assert (act === exp) begin
      n_pass++;
    end else begin
      $display("CHECK FAILED %s expected 0x%h actual 0x%h", name, exp, act);
      n_fail++;
    end
  endtask

  function automatic timer_val_t mtime_at(input longint unsigned c);
    return mtime_ref + timer_val_t'(c - ref_cyc);
  endfunction

  function automatic logic is_mapped(input bus_addr_t a);
    case (a[`TIMER_OFFSET_WIDTH-1:0])
      `TIMER_MTIME_LOW, `TIMER_MTIME_HIGH: return 1'b1;
      `TIMER_MTIMECMP_LOW, `TIMER_MTIMECMP_HIGH: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // Register word seen by a request issued in cycle c
  function automatic bus_data_t model_read(input bus_addr_t a, input longint unsigned c);
    timer_val_t now;
    now = mtime_at(c);
    case (a[`TIMER_OFFSET_WIDTH-1:0])
      `TIMER_MTIME_LOW:     return now[31:0];
      `TIMER_MTIME_HIGH:    return now[63:32];
      `TIMER_MTIMECMP_LOW:  return cmp_ref[31:0];
      `TIMER_MTIMECMP_HIGH: return cmp_ref[63:32];
      default:              return '0;
    endcase
  endfunction

  // Writes take effect at the edge after the request cycle
  task automatic model_write(input bus_addr_t a, input bus_be_t b, input bus_data_t d,
                             input longint unsigned c);
    timer_val_t next;
    next = mtime_at(c) + 64'd1;
    if (b == 4'hF) begin
      case (a[`TIMER_OFFSET_WIDTH-1:0])
        `TIMER_MTIME_LOW: begin
          mtime_ref = {next[63:32], d};
          ref_cyc   = c + 1;
        end
        `TIMER_MTIME_HIGH: begin
          mtime_ref = {d, next[31:0]};
          ref_cyc   = c + 1;
        end
        `TIMER_MTIMECMP_LOW: begin
          cmp_ref[31:0] = d;
        end
        `TIMER_MTIMECMP_HIGH: begin
          cmp_ref[63:32] = d;
        end
        default: begin
          // Unmapped offsets hold no register
        end
      endcase
    end
  endtask

  // Issue one request and wait for its response
  task automatic bus_access(input bus_addr_t a, input logic w, input bus_be_t b,
                            input bus_data_t d, output bus_data_t rd, output logic re);
    int unsigned waited;
    req_cycle = cyc;
    req       = 1'b1;
    addr      = a;
    we        = w;
    be        = b;
    wdata     = d;
    @(posedge clk);
    #1;
    req    = 1'b0;
    addr   = '0;
    we     = 1'b0;
    be     = '0;
    wdata  = '0;
    waited = 0;
    while (!rvalid && waited < RESP_TIMEOUT) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (rvalid) begin
      rd = rdata;
      re = err;
    end else begin
      $display("No response within %0d cycles to the request of cycle %0d",
               RESP_TIMEOUT, req_cycle);
      n_fail++;
      rd = '0;
      re = 1'b1;
    end
  endtask

  // The write response carries the register's old value
  task automatic bus_write(input bus_addr_t a, input bus_be_t b, input bus_data_t d);
    bus_data_t rd;
    logic      re;
    bus_access(a, 1'b1, b, d, rd, re);
    compare_word("timer_rdata_o", model_read(a, req_cycle), rd);
    compare_bit("timer_err_o", ~is_mapped(a), re);
    model_write(a, b, d, req_cycle);
  endtask

  task automatic bus_read(input bus_addr_t a, output bus_data_t rd);
    logic re;
    bus_access(a, 1'b0, 4'h0, '0, rd, re);
    compare_word("timer_rdata_o", model_read(a, req_cycle), rd);
    compare_bit("timer_err_o", ~is_mapped(a), re);
  endtask

  task automatic idle_cycles(input int unsigned n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic start_test();
    test_fail_start = n_fail;
  endtask

  task automatic finish_test(input string name);
    $display("test %s finished, %0d failed checks", name, n_fail - test_fail_start);
  endtask

  initial begin
    bus_data_t  d;
    bus_data_t  rd;
    bus_data_t  upper;
    timer_val_t target;
    lfsr_state = 32'he11bb937;
    n_pass     = 0;
    n_fail     = 0;
    mtime_ref  = '0;
    cmp_ref    = '0;
    ref_cyc    = 0;
    req_cycle  = 0;
    rst_n      = 1'b0;
    req        = 1'b0;
    addr       = '0;
    we         = 1'b0;
    be         = '0;
    wdata      = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;

    start_test();
    compare_bit("timer_intr_o", 1'b0, intr);
    idle_cycles(1);
    // mtime equals mtimecmp right after reset
    compare_bit("timer_intr_o", 1'b1, intr);
    bus_read(ADDR_CMP_LO, rd);
    bus_read(ADDR_CMP_HI, rd);
    bus_read(ADDR_MTIME_LO, rd);
    finish_test("reset and response timing");

    start_test();
    d = rand_bits(32);
    bus_write(ADDR_CMP_LO, 4'hF, d);
    bus_read(ADDR_CMP_LO, rd);
    compare_word("timer_rdata_o", d, rd);
    d = rand_bits(32);
    bus_write(ADDR_CMP_HI, 4'hF, d);
    bus_read(ADDR_CMP_HI, rd);
    compare_word("timer_rdata_o", d, rd);
    // One byte lane off, then all of them
    for (int i = 0; i < 5; i++) begin
      bus_write(ADDR_CMP_LO, (i < 4) ? ~bus_be_t'(1 << i) : 4'h0, rand_bits(32));
      bus_read(ADDR_CMP_LO, rd);
      bus_write(ADDR_CMP_HI, (i < 4) ? ~bus_be_t'(1 << i) : 4'h0, rand_bits(32));
      bus_read(ADDR_CMP_HI, rd);
    end
    finish_test("mtimecmp access");

    start_test();
    bus_write(ADDR_MTIME_LO, 4'hF, rand_bits(32));
    for (int i = 0; i < 6; i++) begin
      idle_cycles(rand_bits(4));
      bus_read(ADDR_MTIME_LO, rd);
      bus_read(ADDR_MTIME_HI, rd);
    end
    // A dropped partial write does not hold the counter
    bus_write(ADDR_MTIME_LO, 4'b1011, rand_bits(32));
    bus_read(ADDR_MTIME_LO, rd);
    bus_write(ADDR_MTIME_LO, 4'hF, 32'hFFFF_FFF0);
    bus_write(ADDR_MTIME_HI, 4'hF, 32'h0000_0005);
    idle_cycles(20);
    bus_read(ADDR_MTIME_HI, rd);
    compare_word("timer_rdata_o", 32'h0000_0006, rd);
    bus_read(ADDR_MTIME_LO, rd);
    finish_test("mtime counting");

    start_test();
    bus_write(ADDR_CMP_HI, 4'hF, 32'hFFFF_FFFF);
    compare_bit("timer_intr_o", 1'b0, intr);
    target = mtime_at(cyc) + INTR_LEAD;
    bus_write(ADDR_CMP_LO, 4'hF, target[31:0]);
    bus_write(ADDR_CMP_HI, 4'hF, target[63:32]);
    // Interrupt follows the compare of the previous cycle
    for (int i = 0; i < INTR_LEAD + 8; i++) begin
      compare_bit("timer_intr_o", mtime_at(cyc - 1) >= cmp_ref, intr);
      idle_cycles(1);
    end
    compare_bit("timer_intr_o", 1'b1, intr);
    bus_write(ADDR_CMP_LO, 4'b1110, rand_bits(32));
    compare_bit("timer_intr_o", 1'b1, intr);
    bus_read(ADDR_CMP_LO, rd);
    bus_write(ADDR_CMP_HI, 4'hF, 32'hFFFF_FFFF);
    compare_bit("timer_intr_o", 1'b0, intr);
    finish_test("interrupt");

    start_test();
    bus_read(bus_addr_t'(16'h1234), rd);
    compare_word("timer_rdata_o", 32'h0, rd);
    bus_write(bus_addr_t'(16'h4008), 4'hF, rand_bits(32));
    bus_write(bus_addr_t'(16'hBFF0), 4'hF, rand_bits(32));
    bus_read(ADDR_MTIME_LO, rd);
    bus_read(ADDR_MTIME_HI, rd);
    bus_read(ADDR_CMP_LO, rd);
    bus_read(ADDR_CMP_HI, rd);
    // Upper address bits are ignored by the timer
    upper = rand_bits(16);
    bus_write({upper[15:0], `TIMER_MTIMECMP_HIGH}, 4'hF, rand_bits(32));
    bus_read(ADDR_CMP_HI, rd);
    upper = rand_bits(16);
    bus_read({upper[15:0], `TIMER_MTIMECMP_HIGH}, rd);
    upper = rand_bits(16);
    bus_read({upper[15:0], `TIMER_MTIME_LOW}, rd);
    upper = rand_bits(16);
    bus_read({upper[15:0], 16'h0010}, rd);
    finish_test("address errors and aliasing");

    $display("checks passed %0d, checks failed %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

endmodule

//--- flist.f
+incdir+src
src/timer_pkg.sv
src/timer_decode.sv
src/timer_counter.sv
src/timer_readback.sv
src/rv_timer.sv
test/tb_rv_timer.sv

//--- Bender.yml
package:
  name: rv_timer

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/timer_pkg.sv
      - src/timer_decode.sv
      - src/timer_counter.sv
      - src/timer_readback.sv
      - src/rv_timer.sv
  - target: test
    include_dirs:
      - src
    files:
      - test/tb_rv_timer.sv
